//--- verilog/autotest_cfg.svh
`ifndef AUTOTEST_CFG_SVH
`define AUTOTEST_CFG_SVH

// sd card geometry
`define AT_SECTOR_BYTES     512
`define AT_START_BLOCK      32'h0010_0000
`define AT_RESULT_OFFSET    32'h0080_0000

// vector sector layout
`define AT_SIGNATURE        32'hAABBCCDD
`define AT_OFS_BLOCK        4
`define AT_OFS_KEY          12
`define AT_OFS_MODE         22
`define AT_OFS_EXPECT       23

// result sector layout, output block starts at byte 0
`define AT_OFS_RES_CYCLES   8

// field sizes in bytes
`define AT_BLOCK_BYTES      8
`define AT_KEY_BYTES        10
`define AT_CYCLES_BYTES     8

`endif

//--- verilog/autotest_pkg.sv
package autotest_pkg;

  typedef logic [63:0] block_t;
  typedef logic [79:0] key_t;
  typedef logic [7:0]  byte_t;
  typedef logic [31:0] sector_addr_t;
  typedef logic [9:0]  byte_idx_t;
  typedef logic [63:0] cycles_t;
  typedef logic [31:0] err_count_t;

  typedef enum logic [4:0] {
    INIT,
    SPI_RESET,
    WAIT_SPI_RESET,
    IDLE,
    OPEN_READ,
    WAIT_READ_OPEN,
    READ_BYTE,
    WAIT_READ_BYTE,
    CHECK_SIGNATURE,
    RUN_UUT,
    COMPARE,
    OPEN_WRITE,
    WAIT_WRITE_OPEN,
    WRITE_BYTE,
    WAIT_WRITE_BYTE,
    WAIT_FLUSH,
    HALT
  } seq_state_t;

endpackage

//--- verilog/vector_regs.sv
`include "autotest_cfg.svh"

module vector_regs (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    clear_i,
  input  logic                    wr_i,
  input  autotest_pkg::byte_idx_t wr_idx_i,
  input  autotest_pkg::byte_t     wr_data_i,
  output logic                    sig_ok_o,
  output autotest_pkg::block_t    block_o,
  output autotest_pkg::key_t      key_o,
  output logic                    mode_o,
  output autotest_pkg::block_t    expected_o
);
  import autotest_pkg::*;

  logic [31:0] sig_q;
  block_t      block_q;
  key_t        key_q;
  logic        mode_q;
  block_t      expect_q;

  byte_idx_t   blk_rel;
  byte_idx_t   key_rel;
  byte_idx_t   exp_rel;
  logic        in_sig;
  logic        in_blk;
  logic        in_key;
  logic        in_mode;
  logic        in_exp;

  // byte position relative to each field start
  assign blk_rel = wr_idx_i - byte_idx_t'(`AT_OFS_BLOCK);
  assign key_rel = wr_idx_i - byte_idx_t'(`AT_OFS_KEY);
  assign exp_rel = wr_idx_i - byte_idx_t'(`AT_OFS_EXPECT);

  // field decode
  assign in_sig  = wr_idx_i < byte_idx_t'(`AT_OFS_BLOCK);
  assign in_blk  = (wr_idx_i >= byte_idx_t'(`AT_OFS_BLOCK)) &&
                   (blk_rel < byte_idx_t'(`AT_BLOCK_BYTES));
  assign in_key  = (wr_idx_i >= byte_idx_t'(`AT_OFS_KEY)) &&
                   (key_rel < byte_idx_t'(`AT_KEY_BYTES));
  assign in_mode = wr_idx_i == byte_idx_t'(`AT_OFS_MODE);
  assign in_exp  = (wr_idx_i >= byte_idx_t'(`AT_OFS_EXPECT)) &&
                   (exp_rel < byte_idx_t'(`AT_BLOCK_BYTES));

  always_ff @(posedge clk) begin
    if (rst || clear_i) begin
      sig_q    <= '0;
      block_q  <= '0;
      key_q    <= '0;
      mode_q   <= 1'b0;
      expect_q <= '0;
    end else if (wr_i) begin
      // signature arrives msb first
      if (in_sig) begin
        sig_q[{~wr_idx_i[1:0], 3'b000} +: 8] <= wr_data_i;
      end
      // the rest are lsb first
      if (in_blk) begin
        block_q[{blk_rel[2:0], 3'b000} +: 8] <= wr_data_i;
      end
      if (in_key) begin
        key_q[{key_rel[3:0], 3'b000} +: 8] <= wr_data_i;
      end
      if (in_mode) begin
        mode_q <= wr_data_i[0];
      end
      if (in_exp) begin
        expect_q[{exp_rel[2:0], 3'b000} +: 8] <= wr_data_i;
      end
    end
  end

  assign sig_ok_o   = sig_q == `AT_SIGNATURE;
  assign block_o    = block_q;
  assign key_o      = key_q;
  assign mode_o     = mode_q;
  assign expected_o = expect_q;

endmodule

//--- verilog/run_monitor.sv
module run_monitor (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     start_i,
  input  logic                     compare_i,
  input  logic                     mode_i,
  input  autotest_pkg::block_t     expected_i,
  input  autotest_pkg::block_t     block_uut_i,
  input  logic                     end_enc_uut_i,
  input  logic                     end_dec_uut_i,
  output logic                     rst_uut_o,
  output logic                     run_done_o,
  output autotest_pkg::block_t     result_o,
  output autotest_pkg::cycles_t    cycles_o,
  output autotest_pkg::err_count_t error_count_o
);
  import autotest_pkg::*;

  logic       running_q;
  logic       done_q;
  logic       end_seen;
  block_t     result_q;
  cycles_t    cycles_q;
  err_count_t err_q;

  // mode 1 is decrypt
  assign end_seen = running_q && (mode_i ? end_dec_uut_i : end_enc_uut_i);

  // run window, the end cycle is still counted
  always_ff @(posedge clk) begin
    if (rst) begin
      running_q <= 1'b0;
      done_q    <= 1'b0;
      cycles_q  <= '0;
    end else if (start_i) begin
      running_q <= 1'b1;
      done_q    <= 1'b0;
      cycles_q  <= '0;
    end else if (running_q) begin
      cycles_q <= cycles_q + cycles_t'(1);
      if (end_seen) begin
        running_q <= 1'b0;
        done_q    <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (end_seen) begin
      result_q <= block_uut_i;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      err_q <= '0;
    end else if (compare_i && (result_q != expected_i)) begin
      err_q <= err_q + err_count_t'(1);
    end
  end

  // uut held in reset outside the window
  assign rst_uut_o     = ~running_q;
  assign run_done_o    = done_q;
  assign result_o      = result_q;
  assign cycles_o      = cycles_q;
  assign error_count_o = err_q;

endmodule

//--- verilog/sd_sequencer.sv
`include "autotest_cfg.svh"

module sd_sequencer (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       spi_busy_i,
  input  autotest_pkg::byte_t        spi_data_out_i,
  output autotest_pkg::sector_addr_t spi_block_addr_o,
  output autotest_pkg::byte_t        spi_data_in_o,
  output logic                       spi_r_block_o,
  output logic                       spi_r_byte_o,
  output logic                       spi_w_block_o,
  output logic                       spi_w_byte_o,
  output logic                       spi_rst_o,
  output logic                       vr_clear_o,
  output logic                       vr_wr_o,
  output autotest_pkg::byte_idx_t    vr_idx_o,
  output autotest_pkg::byte_t        vr_data_o,
  input  logic                       sig_ok_i,
  output logic                       start_o,
  output logic                       compare_o,
  input  logic                       run_done_i,
  input  autotest_pkg::block_t       result_i,
  input  autotest_pkg::cycles_t      cycles_i,
  output logic                       done_o
);
  import autotest_pkg::*;

  seq_state_t   state_q;
  seq_state_t   state_d;
  sector_addr_t addr_q;
  byte_idx_t    byte_cnt_q;
  logic         cnt_clr;
  logic         cnt_inc;
  logic         addr_inc;
  logic         last_byte;
  logic         wr_phase;
  byte_t        wr_byte;

  assign last_byte = byte_cnt_q == byte_idx_t'(`AT_SECTOR_BYTES - 1);

  always_comb begin
    state_d       = state_q;
    cnt_clr       = 1'b0;
    cnt_inc       = 1'b0;
    addr_inc      = 1'b0;
    spi_r_block_o = 1'b0;
    spi_r_byte_o  = 1'b0;
    spi_w_block_o = 1'b0;
    spi_w_byte_o  = 1'b0;
    spi_rst_o     = 1'b0;
    vr_clear_o    = 1'b0;
    vr_wr_o       = 1'b0;
    start_o       = 1'b0;
    compare_o     = 1'b0;
    done_o        = 1'b0;

    case (state_q)
      // one quiet cycle before the host reset
      INIT: state_d = SPI_RESET;
      SPI_RESET: begin
        spi_rst_o = 1'b1;
        if (spi_busy_i) state_d = WAIT_SPI_RESET;
      end
      WAIT_SPI_RESET: begin
        if (!spi_busy_i) state_d = IDLE;
      end
      IDLE: begin
        vr_clear_o = 1'b1;
        cnt_clr    = 1'b1;
        if (!spi_busy_i) state_d = OPEN_READ;
      end
      OPEN_READ: begin
        spi_r_block_o = 1'b1;
        if (spi_busy_i) state_d = WAIT_READ_OPEN;
      end
      WAIT_READ_OPEN: begin
        spi_r_block_o = 1'b1;
        if (!spi_busy_i) state_d = READ_BYTE;
      end
      READ_BYTE: begin
        spi_r_block_o = 1'b1;
        spi_r_byte_o  = 1'b1;
        if (spi_busy_i) state_d = WAIT_READ_BYTE;
      end
      WAIT_READ_BYTE: begin
        spi_r_block_o = 1'b1;
        if (!spi_busy_i) begin
          // data valid once busy drops
          vr_wr_o = 1'b1;
          cnt_inc = 1'b1;
          state_d = last_byte ? CHECK_SIGNATURE : READ_BYTE;
        end
      end
      CHECK_SIGNATURE: begin
        // read block closed, host must settle first
        if (!spi_busy_i) begin
          if (sig_ok_i) begin
            start_o = 1'b1;
            state_d = RUN_UUT;
          end else begin
            state_d = HALT;
          end
        end
      end
      RUN_UUT: begin
        if (run_done_i) state_d = COMPARE;
      end
      COMPARE: begin
        compare_o = 1'b1;
        cnt_clr   = 1'b1;
        state_d   = OPEN_WRITE;
      end
      OPEN_WRITE: begin
        spi_w_block_o = 1'b1;
        if (spi_busy_i) state_d = WAIT_WRITE_OPEN;
      end
      WAIT_WRITE_OPEN: begin
        spi_w_block_o = 1'b1;
        if (!spi_busy_i) state_d = WRITE_BYTE;
      end
      WRITE_BYTE: begin
        spi_w_block_o = 1'b1;
        spi_w_byte_o  = 1'b1;
        if (spi_busy_i) state_d = WAIT_WRITE_BYTE;
      end
      WAIT_WRITE_BYTE: begin
        spi_w_block_o = 1'b1;
        if (!spi_busy_i) begin
          cnt_inc = 1'b1;
          state_d = last_byte ? WAIT_FLUSH : WRITE_BYTE;
        end
      end
      WAIT_FLUSH: begin
        if (!spi_busy_i) begin
          addr_inc = 1'b1;
          state_d  = IDLE;
        end
      end
      HALT: done_o = 1'b1;
      default: state_d = INIT;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q    <= INIT;
      addr_q     <= `AT_START_BLOCK;
      byte_cnt_q <= '0;
    end else begin
      state_q <= state_d;
      if (addr_inc) begin
        addr_q <= addr_q + sector_addr_t'(1);
      end
      if (cnt_clr) begin
        byte_cnt_q <= '0;
      end else if (cnt_inc) begin
        byte_cnt_q <= byte_cnt_q + byte_idx_t'(1);
      end
    end
  end

  // result sector: output block, cycle count, then padding
  always_comb begin
    wr_byte = 8'hFF;
    if (byte_cnt_q < byte_idx_t'(`AT_OFS_RES_CYCLES)) begin
      wr_byte = result_i[{byte_cnt_q[2:0], 3'b000} +: 8];
    end else if (byte_cnt_q < byte_idx_t'(`AT_OFS_RES_CYCLES + `AT_CYCLES_BYTES)) begin
      wr_byte = cycles_i[{byte_cnt_q[2:0], 3'b000} +: 8];
    end
  end

  assign wr_phase = state_q inside {OPEN_WRITE, WAIT_WRITE_OPEN, WRITE_BYTE,
                                    WAIT_WRITE_BYTE, WAIT_FLUSH};

  assign spi_block_addr_o = wr_phase ? addr_q + `AT_RESULT_OFFSET : addr_q;
  assign spi_data_in_o    = wr_byte;
  assign vr_idx_o         = byte_cnt_q;
  assign vr_data_o        = spi_data_out_i;

endmodule

//--- verilog/autotest_top.sv
module autotest_top (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       spi_busy_i,
  input  autotest_pkg::byte_t        spi_data_out_i,
  output autotest_pkg::sector_addr_t spi_block_addr_o,
  output autotest_pkg::byte_t        spi_data_in_o,
  output logic                       spi_r_block_o,
  output logic                       spi_r_byte_o,
  output logic                       spi_w_block_o,
  output logic                       spi_w_byte_o,
  output logic                       spi_rst_o,
  output logic                       rst_uut_o,
  output autotest_pkg::block_t       block_uut_o,
  output autotest_pkg::key_t         key_uut_o,
  output logic                       encdec_uut_o,
  input  autotest_pkg::block_t       block_uut_i,
  input  logic                       end_enc_uut_i,
  input  logic                       end_dec_uut_i,
  output autotest_pkg::err_count_t   error_count_o,
  output logic                       done_o
);
  import autotest_pkg::*;

  logic      vr_clear;
  logic      vr_wr;
  byte_idx_t vr_idx;
  byte_t     vr_data;
  logic      sig_ok;
  logic      start;
  logic      compare;
  logic      run_done;
  block_t    result;
  block_t    expected;
  cycles_t   cycles;

  sd_sequencer u_seq (
    .clk              (clk),
    .rst              (rst),
    .spi_busy_i       (spi_busy_i),
    .spi_data_out_i   (spi_data_out_i),
    .spi_block_addr_o (spi_block_addr_o),
    .spi_data_in_o    (spi_data_in_o),
    .spi_r_block_o    (spi_r_block_o),
    .spi_r_byte_o     (spi_r_byte_o),
    .spi_w_block_o    (spi_w_block_o),
    .spi_w_byte_o     (spi_w_byte_o),
    .spi_rst_o        (spi_rst_o),
    .vr_clear_o       (vr_clear),
    .vr_wr_o          (vr_wr),
    .vr_idx_o         (vr_idx),
    .vr_data_o        (vr_data),
    .sig_ok_i         (sig_ok),
    .start_o          (start),
    .compare_o        (compare),
    .run_done_i       (run_done),
    .result_i         (result),
    .cycles_i         (cycles),
    .done_o           (done_o)
  );

  vector_regs u_regs (
    .clk        (clk),
    .rst        (rst),
    .clear_i    (vr_clear),
    .wr_i       (vr_wr),
    .wr_idx_i   (vr_idx),
    .wr_data_i  (vr_data),
    .sig_ok_o   (sig_ok),
    .block_o    (block_uut_o),
    .key_o      (key_uut_o),
    .mode_o     (encdec_uut_o),
    .expected_o (expected)
  );

  run_monitor u_mon (
    .clk           (clk),
    .rst           (rst),
    .start_i       (start),
    .compare_i     (compare),
    .mode_i        (encdec_uut_o),
    .expected_i    (expected),
    .block_uut_i   (block_uut_i),
    .end_enc_uut_i (end_enc_uut_i),
    .end_dec_uut_i (end_dec_uut_i),
    .rst_uut_o     (rst_uut_o),
    .run_done_o    (run_done),
    .result_o      (result),
    .cycles_o      (cycles),
    .error_count_o (error_count_o)
  );

endmodule

//--- sim/autotest_assert.sv
`include "autotest_cfg.svh"

module autotest_assert (
  input logic                       clk,
  input logic                       rst,
  input logic                       spi_busy_i,
  input autotest_pkg::byte_t        spi_data_out_i,
  input autotest_pkg::sector_addr_t spi_block_addr_o,
  input autotest_pkg::byte_t        spi_data_in_o,
  input logic                       spi_r_block_o,
  input logic                       spi_r_byte_o,
  input logic                       spi_w_block_o,
  input logic                       spi_w_byte_o,
  input logic                       spi_rst_o,
  input logic                       rst_uut_o,
  input autotest_pkg::block_t       block_uut_o,
  input autotest_pkg::key_t         key_uut_o,
  input logic                       encdec_uut_o,
  input logic                       end_enc_uut_i,
  input logic                       end_dec_uut_i,
  input autotest_pkg::err_count_t   error_count_o,
  input logic                       done_o
);
  import autotest_pkg::*;

  byte_t        rd_bytes [0:31];
  byte_idx_t    rd_idx;
  logic         rd_pend;
  sector_addr_t rd_addr;
  byte_idx_t    wr_idx;
  logic         wr_pend;
  cycles_t      meas;
  logic         meas_on;
  logic         end_sel;
  logic         rst_uut_q;
  block_t       ld_block;
  key_t         ld_key;
  block_t       ld_expect;
  logic [31:0]  ld_sig;
  block_t       xor_out;
  logic         vec_bad;
  logic         sig_bad;
  byte_t        wb_exp;
  int           n_fail = 0;

  // end flag of the mode read from the card, mode 1 is decrypt
  assign end_sel = rd_bytes[`AT_OFS_MODE][0] ? end_dec_uut_i : end_enc_uut_i;

  // shadow of the card traffic as the host sees it
  always_ff @(posedge clk) begin
    if (rst) begin
      rd_idx    <= '0;
      rd_pend   <= 1'b0;
      rd_addr   <= '0;
      wr_idx    <= '0;
      wr_pend   <= 1'b0;
      meas      <= '0;
      meas_on   <= 1'b0;
      rst_uut_q <= 1'b1;
    end else begin
      rst_uut_q <= rst_uut_o;
      if (!spi_r_block_o) begin
        rd_idx  <= '0;
        rd_pend <= 1'b0;
      end else begin
        rd_addr <= spi_block_addr_o;
        if (spi_r_byte_o && spi_busy_i) begin
          rd_pend <= 1'b1;
        end else if (rd_pend && !spi_busy_i) begin
          if (rd_idx < byte_idx_t'(32)) begin
            rd_bytes[rd_idx[4:0]] <= spi_data_out_i;
          end
          rd_idx  <= rd_idx + byte_idx_t'(1);
          rd_pend <= 1'b0;
        end
      end
      if (!spi_w_block_o) begin
        wr_idx  <= '0;
        wr_pend <= 1'b0;
      end else if (spi_w_byte_o && spi_busy_i) begin
        wr_pend <= 1'b1;
      end else if (wr_pend && !spi_busy_i) begin
        wr_idx  <= wr_idx + byte_idx_t'(1);
        wr_pend <= 1'b0;
      end
      // uut run length, released cycle through the cycle the end flag shows
      if (!rst_uut_o && rst_uut_q) begin
        meas    <= cycles_t'(1);
        meas_on <= !end_sel;
      end else if (meas_on) begin
        meas    <= meas + cycles_t'(1);
        meas_on <= !end_sel;
      end
    end
  end

  always_comb begin
    ld_sig = {rd_bytes[0], rd_bytes[1], rd_bytes[2], rd_bytes[3]};
    for (int k = 0; k < 8; k++) begin
      ld_block[8*k +: 8]  = rd_bytes[`AT_OFS_BLOCK + k];
      ld_expect[8*k +: 8] = rd_bytes[`AT_OFS_EXPECT + k];
    end
    for (int k = 0; k < 10; k++) begin
      ld_key[8*k +: 8] = rd_bytes[`AT_OFS_KEY + k];
    end
  end

  assign xor_out = ld_block ^ ld_key[63:0];
  assign vec_bad = ld_expect != xor_out;
  assign sig_bad = ld_sig != `AT_SIGNATURE;

  always_comb begin
    wb_exp = 8'hFF;
    if (wr_idx < byte_idx_t'(8)) begin
      wb_exp = xor_out[{wr_idx[2:0], 3'b000} +: 8];
    end else if (wr_idx < byte_idx_t'(16)) begin
      wb_exp = meas[{wr_idx[2:0], 3'b000} +: 8];
    end
  end

  a_reset: assert property (@(posedge clk) $fell(rst) |->
      (!spi_r_block_o && !spi_r_byte_o && !spi_w_block_o && !spi_w_byte_o &&
       !spi_rst_o && !done_o && error_count_o == '0 && rst_uut_o))
    else begin
      $error("outputs not in their reset state after rst release");
      n_fail = n_fail + 1;
    end

  a_rbyte: assert property (@(posedge clk) disable iff (rst)
      $rose(spi_r_byte_o) |-> !spi_busy_i)
    else begin
      $error("read byte request raised while the host was busy");
      n_fail = n_fail + 1;
    end

  a_wbyte: assert property (@(posedge clk) disable iff (rst)
      $rose(spi_w_byte_o) |-> !spi_busy_i)
    else begin
      $error("write byte request raised while the host was busy");
      n_fail = n_fail + 1;
    end

  a_wdata_stable: assert property (@(posedge clk) disable iff (rst)
      (spi_w_byte_o && $past(spi_w_byte_o)) |-> $stable(spi_data_in_o))
    else begin
      $error("Fail spi_data_in_o changed during request, now %h", spi_data_in_o);
      n_fail = n_fail + 1;
    end

  a_load: assert property (@(posedge clk) disable iff (rst)
      $fell(rst_uut_o) |-> (block_uut_o == ld_block && key_uut_o == ld_key &&
                            encdec_uut_o == rd_bytes[`AT_OFS_MODE][0]))
    else begin
      $error("Fail block_uut_o/key_uut_o/encdec_uut_o %h %h %h, expected %h %h %h",
             block_uut_o, key_uut_o, encdec_uut_o, ld_block, ld_key,
             rd_bytes[`AT_OFS_MODE][0]);
      n_fail = n_fail + 1;
    end

  a_err_step: assert property (@(posedge clk) disable iff (rst)
      !$stable(error_count_o) |->
        (error_count_o == $past(error_count_o) + err_count_t'(1) && vec_bad))
    else begin
      $error("Fail error_count_o: %h, previous %h", error_count_o, $past(error_count_o));
      n_fail = n_fail + 1;
    end

  a_err_done: assert property (@(posedge clk) disable iff (rst)
      $rose(done_o) |-> error_count_o == err_count_t'(1))
    else begin
      $error("Fail error_count_o at done: %h, expected %h", error_count_o, 32'h1);
      n_fail = n_fail + 1;
    end

  a_wr_addr: assert property (@(posedge clk) disable iff (rst)
      $rose(spi_w_block_o) |-> spi_block_addr_o == rd_addr + `AT_RESULT_OFFSET)
    else begin
      $error("Fail spi_block_addr_o: %h, expected %h", spi_block_addr_o,
             rd_addr + `AT_RESULT_OFFSET);
      n_fail = n_fail + 1;
    end

  a_wr_data: assert property (@(posedge clk) disable iff (rst)
      (spi_w_byte_o && spi_busy_i) |-> spi_data_in_o == wb_exp)
    else begin
      $error("Fail spi_data_in_o at byte %h: %h, expected %h", wr_idx, spi_data_in_o,
             wb_exp);
      n_fail = n_fail + 1;
    end

  a_halt_hold: assert property (@(posedge clk) disable iff (rst)
      $past(done_o) |-> done_o)
    else begin
      $error("done_o dropped after the run had ended");
      n_fail = n_fail + 1;
    end

  a_halt_quiet: assert property (@(posedge clk) disable iff (rst)
      $rose(spi_w_block_o) |-> !sig_bad)
    else begin
      $error("result sector opened for a sector with a bad signature");
      n_fail = n_fail + 1;
    end

  a_halt_cause: assert property (@(posedge clk) disable iff (rst)
      $rose(done_o) |-> sig_bad)
    else begin
      $error("done_o rose although the last sector had a good signature");
      n_fail = n_fail + 1;
    end

endmodule

bind autotest_top autotest_assert u_chk (
  .clk              (clk),
  .rst              (rst),
  .spi_busy_i       (spi_busy_i),
  .spi_data_out_i   (spi_data_out_i),
  .spi_block_addr_o (spi_block_addr_o),
  .spi_data_in_o    (spi_data_in_o),
  .spi_r_block_o    (spi_r_block_o),
  .spi_r_byte_o     (spi_r_byte_o),
  .spi_w_block_o    (spi_w_block_o),
  .spi_w_byte_o     (spi_w_byte_o),
  .spi_rst_o        (spi_rst_o),
  .rst_uut_o        (rst_uut_o),
  .block_uut_o      (block_uut_o),
  .key_uut_o        (key_uut_o),
  .encdec_uut_o     (encdec_uut_o),
  .end_enc_uut_i    (end_enc_uut_i),
  .end_dec_uut_i    (end_dec_uut_i),
  .error_count_o    (error_count_o),
  .done_o           (done_o)
);

//--- sim/tb_autotest.sv
`include "autotest_cfg.svh"

module tb_autotest;
  import autotest_pkg::*;

  logic         clk;
  logic         rst;
  logic         spi_busy_i;
  byte_t        spi_data_out_i;
  sector_addr_t spi_block_addr_o;
  byte_t        spi_data_in_o;
  logic         spi_r_block_o;
  logic         spi_r_byte_o;
  logic         spi_w_block_o;
  logic         spi_w_byte_o;
  logic         spi_rst_o;
  logic         rst_uut_o;
  block_t       block_uut_o;
  key_t         key_uut_o;
  logic         encdec_uut_o;
  block_t       block_uut_i;
  logic         end_enc_uut_i;
  logic         end_dec_uut_i;
  err_count_t   error_count_o;
  logic         done_o;

  logic [31:0]  rng;
  logic [31:0]  uut_rng;
  byte_t        sd_mem [0:3][0:511];
  sector_addr_t wr_addrs [$];
  logic         h_active;
  logic         h_rd_op;
  logic [31:0]  h_delay;
  logic         rb_open;
  logic         wb_open;
  sector_addr_t rd_sector;
  sector_addr_t wr_sector;
  byte_idx_t    rd_ptr;
  logic [31:0]  uut_wait;
  int           n_timeout;
  int           n_other;
  int           n_assert;
  int           cyc;

  autotest_top uut (
    .clk(clk), .rst(rst),
    .spi_busy_i(spi_busy_i), .spi_data_out_i(spi_data_out_i),
    .spi_block_addr_o(spi_block_addr_o), .spi_data_in_o(spi_data_in_o),
    .spi_r_block_o(spi_r_block_o), .spi_r_byte_o(spi_r_byte_o),
    .spi_w_block_o(spi_w_block_o), .spi_w_byte_o(spi_w_byte_o),
    .spi_rst_o(spi_rst_o), .rst_uut_o(rst_uut_o),
    .block_uut_o(block_uut_o), .key_uut_o(key_uut_o), .encdec_uut_o(encdec_uut_o),
    .block_uut_i(block_uut_i), .end_enc_uut_i(end_enc_uut_i),
    .end_dec_uut_i(end_dec_uut_i), .error_count_o(error_count_o), .done_o(done_o)
  );

  always #20 clk = ~clk;

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] next_rand();
    rng = xorshift(rng);
    return rng;
  endfunction

  // sectors 0..2 are vectors, 1 has a wrong expected block, 3 a bad signature
  task automatic build_sectors();
    logic [31:0] r;
    block_t      blk;
    key_t        key;
    block_t      expect_blk;
    for (int s = 0; s < 4; s++) begin
      for (int i = 0; i < 512; i++) begin
        sd_mem[s][i] = byte_t'(i ^ (i >> 8) ^ (s << 4) ^ 8'h5A);
      end
      blk[63:32]  = next_rand();
      blk[31:0]   = next_rand();
      r           = next_rand();
      key[79:64]  = r[15:0];
      key[63:32]  = next_rand();
      key[31:0]   = next_rand();
      expect_blk  = blk ^ key[63:0];
      if (s == 1) begin
        expect_blk[0] = ~expect_blk[0];
      end
      sd_mem[s][0] = (s == 3) ? 8'h55 : 8'hAA;
      sd_mem[s][1] = 8'hBB;
      sd_mem[s][2] = 8'hCC;
      sd_mem[s][3] = 8'hDD;
      for (int i = 0; i < 8; i++) begin
        sd_mem[s][`AT_OFS_BLOCK + i]  = blk[8*i +: 8];
        sd_mem[s][`AT_OFS_EXPECT + i] = expect_blk[8*i +: 8];
      end
      for (int i = 0; i < 10; i++) begin
        sd_mem[s][`AT_OFS_KEY + i] = key[8*i +: 8];
      end
      // odd sectors decrypt
      sd_mem[s][`AT_OFS_MODE] = {7'b0, s[0]};
    end
  endtask

  function automatic byte_t sector_byte(sector_addr_t a, byte_idx_t i);
    sector_addr_t rel;
    rel = a - `AT_START_BLOCK;
    if (rel < sector_addr_t'(4)) begin
      return sd_mem[rel[1:0]][i[8:0]];
    end
    return 8'h00;
  endfunction

  task automatic start_busy();
    spi_busy_i <= 1'b1;
    h_active   <= 1'b1;
    h_delay    <= next_rand() & 32'd3;
  endtask

  // spi host and card model
  always @(posedge clk) begin
    if (rst) begin
      spi_busy_i <= 1'b0;
      h_active   <= 1'b0;
      h_rd_op    <= 1'b0;
      rb_open    <= 1'b0;
      wb_open    <= 1'b0;
      rd_ptr     <= '0;
    end else if (h_active) begin
      if (h_delay == 32'd0) begin
        spi_busy_i <= 1'b0;
        h_active   <= 1'b0;
        if (h_rd_op) begin
          spi_data_out_i <= sector_byte(rd_sector, rd_ptr);
          rd_ptr         <= rd_ptr + byte_idx_t'(1);
        end
      end else begin
        h_delay <= h_delay - 32'd1;
      end
    end else if (spi_rst_o) begin
      h_rd_op <= 1'b0;
      start_busy();
    end else if (spi_r_block_o && !rb_open) begin
      rb_open   <= 1'b1;
      rd_sector <= spi_block_addr_o;
      rd_ptr    <= '0;
      h_rd_op   <= 1'b0;
      start_busy();
    end else if (!spi_r_block_o && rb_open) begin
      rb_open <= 1'b0;
      h_rd_op <= 1'b0;
      start_busy();
    end else if (spi_w_block_o && !wb_open) begin
      wb_open   <= 1'b1;
      wr_sector <= spi_block_addr_o;
      h_rd_op   <= 1'b0;
      start_busy();
    end else if (!spi_w_block_o && wb_open) begin
      wb_open <= 1'b0;
      h_rd_op <= 1'b0;
      wr_addrs.push_back(wr_sector);
      start_busy();
    end else if (spi_r_byte_o) begin
      h_rd_op <= 1'b1;
      start_busy();
    end else if (spi_w_byte_o) begin
      h_rd_op <= 1'b0;
      start_busy();
    end
  end

  // cipher stand-in, the flag of the selected mode ends the run
  always @(posedge clk) begin
    block_uut_i <= block_uut_o ^ key_uut_o[63:0];
    if (rst || rst_uut_o) begin
      end_enc_uut_i <= 1'b0;
      end_dec_uut_i <= 1'b0;
      uut_rng       <= xorshift(uut_rng);
      uut_wait      <= (uut_rng & 32'd7) + 32'd1;
    end else if (uut_wait != 32'd0) begin
      uut_wait <= uut_wait - 32'd1;
    end else if (encdec_uut_o) begin
      end_dec_uut_i <= 1'b1;
    end else begin
      end_enc_uut_i <= 1'b1;
    end
  end

  initial begin
    clk            = 1'b0;
    rst            = 1'b1;
    spi_busy_i     = 1'b0;
    spi_data_out_i = '0;
    block_uut_i    = '0;
    end_enc_uut_i  = 1'b0;
    end_dec_uut_i  = 1'b0;
    n_timeout      = 0;
    n_other        = 0;
    rng            = 32'h6881;
    // uut delays run on their own generator state
    uut_rng        = 32'h6881;
    build_sectors();

    repeat (5) @(posedge clk);
    rst <= 1'b0;

    cyc = 0;
    while (!done_o && cyc < 200000) begin
      @(posedge clk);
      cyc = cyc + 1;
    end
    if (!done_o) begin
      $display("timeout: done_o never rose");
      n_timeout = n_timeout + 1;
    end else begin
      // let the halt checks watch a few more cycles
      repeat (20) @(posedge clk);
      if (wr_addrs.size() != 3) begin
        $display("expected three result sectors, the card got %0d", wr_addrs.size());
        n_other = n_other + 1;
      end
      foreach (wr_addrs[k]) begin
        if (wr_addrs[k] != `AT_START_BLOCK + sector_addr_t'(k) + `AT_RESULT_OFFSET) begin
          $display("Fail spi_block_addr_o of result sector %0d: %h, expected %h", k,
                   wr_addrs[k], `AT_START_BLOCK + sector_addr_t'(k) + `AT_RESULT_OFFSET);
          n_other = n_other + 1;
        end
      end
    end

    n_assert = uut.u_chk.n_fail;
    $display("errors: assertions %0d, timeouts %0d, other %0d",
             n_assert, n_timeout, n_other);
    if (n_assert + n_timeout + n_other == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

//--- all.f
+incdir+verilog
verilog/autotest_pkg.sv
verilog/vector_regs.sv
verilog/run_monitor.sv
verilog/sd_sequencer.sv
verilog/autotest_top.sv
sim/autotest_assert.sv
sim/tb_autotest.sv

//--- run_sim.sh
#!/bin/sh
# build and run the autotest simulation with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f all.f --top-module tb_autotest -o sim_autotest
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

./obj_dir/sim_autotest +verilator+error+limit+1000 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Something failed" sim.log; then
  exit 1
fi

if ! grep -q "Everything OK" sim.log; then
  echo "simulation log has no verdict"
  exit 1
fi

exit 0
